/* Bender.yml */
package:
  name: updi_programmer

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/updi_pkg.sv
      - hdl/updi_link_if.sv
      - hdl/updi_tx_framer.sv
      - hdl/updi_rx_collector.sv
      - hdl/updi_sequencer.sv
      - hdl/updi_programmer.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_clock.sv
      - test/updi_programmer_sva.sv
      - test/tb_updi_programmer.sv

/* hdl/updi_cfg.svh */
// UPDI protocol constants
`ifndef UPDI_CFG_SVH
`define UPDI_CFG_SVH

// sync character that opens every frame
`define UPDI_SYNC 8'h55

// opcode fields, upper three bits of the opcode byte
`define UPDI_OP_LDCS 3'b100
`define UPDI_OP_STCS 3'b110
`define UPDI_OP_KEY 3'b111

// control/status space addresses
`define UPDI_CS_STATUSA 4'h0
`define UPDI_CS_ASI_SYS_STATUS 4'hB
`define UPDI_CS_ASI_RESET_REQ 4'h8

// written to ASI_RESET_REQ to hold the core in reset
`define UPDI_RESET_SIGNATURE 8'h59

// "NVMErase", goes out least significant byte first
`define UPDI_KEY_CHIPERASE 64'h4E56_4D45_7261_7365
`define UPDI_KEY_SIZE_64 2'b00

// timing in clock cycles
`define UPDI_RX_TIMEOUT_CLKS 16'd200
`define UPDI_RESET_WAIT_CLKS 16'd100

`endif

/* hdl/updi_link_if.sv */
// UPDI sequencer link
`timescale 1ns/1ps
`default_nettype none

interface updi_link_if;

	// frame request, fields valid with tx_start only
	logic tx_start;
	updi_pkg::instr_kind_e tx_kind;
	logic [3:0] tx_cs_addr;
	logic [7:0] tx_data;
	logic tx_done;

	// single byte response
	logic rx_start;
	logic [7:0] rx_byte;
	logic rx_valid;
	logic rx_timeout;

	modport seq (
		output tx_start, tx_kind, tx_cs_addr, tx_data, rx_start,
		input tx_done, rx_byte, rx_valid, rx_timeout
	);

	modport tx (
		input tx_start, tx_kind, tx_cs_addr, tx_data,
		output tx_done
	);

	modport rx (
		input rx_start,
		output rx_byte, rx_valid, rx_timeout
	);

endinterface

`default_nettype wire

/* hdl/updi_pkg.sv */
// UPDI programmer types
`default_nettype none

package updi_pkg;

	// instructions the framer knows how to send
	typedef enum logic [1:0] {
		INSTR_LDCS,
		INSTR_STCS,
		INSTR_KEY
	} instr_kind_e;

	// opcode byte for LDCS and STCS
	typedef struct packed {
		logic [2:0] op;
		logic rsvd;
		logic [3:0] addr;
	} opcode_cs_t;

	// opcode byte for KEY
	typedef struct packed {
		logic [2:0] op;
		logic [2:0] rsvd;
		logic [1:0] size;
	} opcode_key_t;

	// same byte on the wire, decoded per instruction
	typedef union packed {
		opcode_cs_t cs;
		opcode_key_t key;
	} opcode_u;

	// result of a programming run
	typedef enum logic [1:0] {
		ERR_NONE,
		ERR_STATUS_ZERO,
		ERR_KEY_STATUS,
		ERR_RX_TIMEOUT
	} error_code_e;

endpackage

`default_nettype wire

/* hdl/updi_programmer.sv */
// UPDI programmer top level
`timescale 1ns/1ps
`default_nettype none

module updi_programmer (
	input wire logic clk,
	input wire logic rst,

	// run control
	input wire logic start,
	output logic busy,
	output logic done,
	output logic error,
	output logic [1:0] error_code,

	// UART TX FIFO
	output logic [7:0] uart_tx_data,
	output logic uart_tx_wr_en,
	input wire logic uart_tx_full,

	// UART RX FIFO, echo already removed
	input wire logic [7:0] uart_rx_data,
	output logic uart_rx_rd_en,
	input wire logic uart_rx_empty,

	// double break generator
	output logic double_break_start,
	input wire logic double_break_done
);

	updi_link_if link ();

	updi_pkg::error_code_e seq_error_code;

	assign error_code = seq_error_code;

	updi_sequencer seq_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.error(error),
		.error_code(seq_error_code),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done),
		.link(link.seq)
	);

	updi_tx_framer framer_inst (
		.clk(clk),
		.rst(rst),
		.link(link.tx),
		.uart_tx_data(uart_tx_data),
		.uart_tx_wr_en(uart_tx_wr_en),
		.uart_tx_full(uart_tx_full)
	);

	updi_rx_collector collector_inst (
		.clk(clk),
		.rst(rst),
		.link(link.rx),
		.uart_rx_data(uart_rx_data),
		.uart_rx_rd_en(uart_rx_rd_en),
		.uart_rx_empty(uart_rx_empty)
	);

endmodule

`default_nettype wire

/* hdl/updi_rx_collector.sv */
// UPDI response collector
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module updi_rx_collector (
	input wire logic clk,
	input wire logic rst,
	updi_link_if.rx link,
	input wire logic [7:0] uart_rx_data,
	output logic uart_rx_rd_en,
	input wire logic uart_rx_empty
);

	logic armed;
	logic pending;
	logic [15:0] timer;
	logic [7:0] byte_q;

	// single pop once something is there
	assign uart_rx_rd_en = armed && !uart_rx_empty;

	// popped byte shows up one cycle after the strobe
	assign link.rx_valid = pending;
	assign link.rx_byte = pending ? uart_rx_data : byte_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			armed <= 1'b0;
			pending <= 1'b0;
			timer <= 16'd0;
			link.rx_timeout <= 1'b0;
		end else begin
			pending <= uart_rx_rd_en;
			link.rx_timeout <= 1'b0;
			if (link.rx_start) begin
				armed <= 1'b1;
				timer <= 16'd0;
			end else if (uart_rx_rd_en) begin
				armed <= 1'b0;
			end else if (armed) begin
				// still empty, give up at the limit
				if (timer == `UPDI_RX_TIMEOUT_CLKS - 16'd1) begin
					armed <= 1'b0;
					link.rx_timeout <= 1'b1;
				end else begin
					timer <= timer + 16'd1;
				end
			end
		end
	end

	// keep the byte around after the valid pulse
	always_ff @(posedge clk) begin
		if (pending) begin
			byte_q <= uart_rx_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/updi_sequencer.sv */
// UPDI chip erase sequencer
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module updi_sequencer (
	input wire logic clk,
	input wire logic rst,
	input wire logic start,
	output logic busy,
	output logic done,
	output logic error,
	output updi_pkg::error_code_e error_code,
	output logic double_break_start,
	input wire logic double_break_done,
	updi_link_if.seq link
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_BREAK,
		S_BREAK_WAIT,
		S_STAT_REQ,
		S_STAT_WAIT,
		S_KEY_REQ,
		S_KEY_WAIT,
		S_KSTAT_REQ,
		S_KSTAT_WAIT,
		S_RSET_REQ,
		S_RSET_WAIT,
		S_RCLR_REQ,
		S_RCLR_WAIT,
		S_SETTLE,
		S_END
	} state_e;

	state_e state;
	logic tx_sent;
	logic rx_got;
	logic rx_lost;
	logic [15:0] wait_cnt;

	logic frame_ok;
	logic reply_ok;
	logic reply_lost;

	// frame and response finish in either order
	assign frame_ok = tx_sent || link.tx_done;
	assign reply_ok = rx_got || link.rx_valid;
	assign reply_lost = rx_lost || link.rx_timeout;

	assign busy = state != S_IDLE;
	assign done = state == S_END && error_code == updi_pkg::ERR_NONE;
	assign error = state == S_END && error_code != updi_pkg::ERR_NONE;
	assign double_break_start = state == S_BREAK;

	// requests to framer and collector
	always_comb begin
		link.tx_start = 1'b0;
		link.tx_kind = updi_pkg::INSTR_LDCS;
		link.tx_cs_addr = 4'h0;
		link.tx_data = 8'h00;
		link.rx_start = 1'b0;
		case (state)
			S_STAT_REQ: begin
				link.tx_start = 1'b1;
				link.tx_cs_addr = `UPDI_CS_STATUSA;
				link.rx_start = 1'b1;
			end
			S_KEY_REQ: begin
				link.tx_start = 1'b1;
				link.tx_kind = updi_pkg::INSTR_KEY;
			end
			S_KSTAT_REQ: begin
				link.tx_start = 1'b1;
				link.tx_cs_addr = `UPDI_CS_ASI_SYS_STATUS;
				link.rx_start = 1'b1;
			end
			S_RSET_REQ, S_RCLR_REQ: begin
				link.tx_start = 1'b1;
				link.tx_kind = updi_pkg::INSTR_STCS;
				link.tx_cs_addr = `UPDI_CS_ASI_RESET_REQ;
				link.tx_data = (state == S_RSET_REQ) ? `UPDI_RESET_SIGNATURE : 8'h00;
			end
			default: begin
			end
		endcase
	end

	// completion flags cleared with each new request
	always_ff @(posedge clk) begin
		if (rst || link.tx_start) begin
			tx_sent <= 1'b0;
			rx_got <= 1'b0;
			rx_lost <= 1'b0;
		end else begin
			if (link.tx_done)
				tx_sent <= 1'b1;
			if (link.rx_valid)
				rx_got <= 1'b1;
			if (link.rx_timeout)
				rx_lost <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			error_code <= updi_pkg::ERR_NONE;
			wait_cnt <= 16'd0;
		end else begin
			case (state)
				S_IDLE: if (start) begin
					state <= S_BREAK;
					error_code <= updi_pkg::ERR_NONE;
				end
				S_BREAK: state <= S_BREAK_WAIT;
				S_BREAK_WAIT: if (double_break_done) state <= S_STAT_REQ;
				S_STAT_REQ: state <= S_STAT_WAIT;
				S_STAT_WAIT: if (frame_ok && (reply_ok || reply_lost)) begin
					if (!reply_ok) begin
						error_code <= updi_pkg::ERR_RX_TIMEOUT;
						state <= S_END;
					end else if (link.rx_byte == 8'h00) begin
						// target not responding properly
						error_code <= updi_pkg::ERR_STATUS_ZERO;
						state <= S_END;
					end else begin
						state <= S_KEY_REQ;
					end
				end
				S_KEY_REQ: state <= S_KEY_WAIT;
				S_KEY_WAIT: if (frame_ok) state <= S_KSTAT_REQ;
				S_KSTAT_REQ: state <= S_KSTAT_WAIT;
				S_KSTAT_WAIT: if (frame_ok && (reply_ok || reply_lost)) begin
					if (!reply_ok) begin
						error_code <= updi_pkg::ERR_RX_TIMEOUT;
						state <= S_END;
					end else if (link.rx_byte[3]) begin
						// bit 3 set means the key was not accepted
						error_code <= updi_pkg::ERR_KEY_STATUS;
						state <= S_END;
					end else begin
						state <= S_RSET_REQ;
					end
				end
				S_RSET_REQ: state <= S_RSET_WAIT;
				S_RSET_WAIT: if (frame_ok) state <= S_RCLR_REQ;
				S_RCLR_REQ: state <= S_RCLR_WAIT;
				S_RCLR_WAIT: if (frame_ok) begin
					wait_cnt <= 16'd0;
					state <= S_SETTLE;
				end
				S_SETTLE: begin
					if (wait_cnt == `UPDI_RESET_WAIT_CLKS - 16'd1)
						state <= S_END;
					else
						wait_cnt <= wait_cnt + 16'd1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/updi_tx_framer.sv */
// UPDI frame transmitter
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module updi_tx_framer (
	input wire logic clk,
	input wire logic rst,
	updi_link_if.tx link,
	output logic [7:0] uart_tx_data,
	output logic uart_tx_wr_en,
	input wire logic uart_tx_full
);

	logic active;
	logic [3:0] idx;
	logic [3:0] last_idx;
	logic [7:0] op_byte;
	logic [63:0] payload;

	updi_pkg::opcode_u next_op;
	logic [63:0] next_payload;
	logic [3:0] next_last;

	// opcode byte and payload for the requested instruction
	always_comb begin
		next_op = '0;
		next_payload = '0;
		next_last = 4'd1;
		case (link.tx_kind)
			updi_pkg::INSTR_STCS: begin
				next_op.cs.op = `UPDI_OP_STCS;
				next_op.cs.addr = link.tx_cs_addr;
				next_payload = {56'b0, link.tx_data};
				next_last = 4'd2;
			end
			updi_pkg::INSTR_KEY: begin
				next_op.key.op = `UPDI_OP_KEY;
				next_op.key.size = `UPDI_KEY_SIZE_64;
				next_payload = `UPDI_KEY_CHIPERASE;
				next_last = 4'd9;
			end
			default: begin
				next_op.cs.op = `UPDI_OP_LDCS;
				next_op.cs.addr = link.tx_cs_addr;
			end
		endcase
	end

	// one byte per cycle unless the FIFO pushes back
	assign uart_tx_wr_en = active && !uart_tx_full;

	always_comb begin
		case (idx)
			4'd0: uart_tx_data = `UPDI_SYNC;
			4'd1: uart_tx_data = op_byte;
			default: uart_tx_data = payload[7:0];
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			idx <= 4'd0;
			link.tx_done <= 1'b0;
		end else begin
			link.tx_done <= 1'b0;
			if (link.tx_start) begin
				active <= 1'b1;
				idx <= 4'd0;
			end else if (uart_tx_wr_en) begin
				// last byte written, report next cycle
				if (idx == last_idx) begin
					active <= 1'b0;
					link.tx_done <= 1'b1;
				end
				idx <= idx + 4'd1;
			end
		end
	end

	// payload drains low byte first
	always_ff @(posedge clk) begin
		if (link.tx_start) begin
			op_byte <= next_op;
			payload <= next_payload;
			last_idx <= next_last;
		end else if (uart_tx_wr_en && idx >= 4'd2) begin
			payload <= {8'h00, payload[63:8]};
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hdl
hdl/updi_pkg.sv
hdl/updi_link_if.sv
hdl/updi_tx_framer.sv
hdl/updi_rx_collector.sv
hdl/updi_sequencer.sv
hdl/updi_programmer.sv
test/tb_clock.sv
test/updi_programmer_sva.sv
test/tb_updi_programmer.sv

/* test/tb_clock.sv */
// testbench clock source
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* test/tb_updi_programmer.sv */
// UPDI programmer testbench
`timescale 1ns/1ps
`default_nettype none
`include "updi_cfg.svh"

module tb_updi_programmer;

	localparam int CLK_PERIOD_NS = 100;
	localparam int NUM_SEQ = 40;
	// break, 20 bytes at 4 cycles each, both timeouts, settling, overhead
	localparam int SEQ_MAX_CLKS = 22 + 4 * 20 + 2 * int'(`UPDI_RX_TIMEOUT_CLKS)
		+ int'(`UPDI_RESET_WAIT_CLKS) + 40;
	localparam int WATCHDOG_NS = CLK_PERIOD_NS * (NUM_SEQ * (SEQ_MAX_CLKS + 4) + 20);

	logic clk;
	logic rst;
	logic start;
	logic busy;
	logic done;
	logic error;
	logic [1:0] error_code;
	logic [7:0] uart_tx_data;
	logic uart_tx_wr_en;
	logic uart_tx_full;
	logic [7:0] uart_rx_data;
	logic uart_rx_rd_en;
	logic uart_rx_empty;
	logic double_break_start;
	logic double_break_done;

	integer seed;
	int errors;
	int done_runs;
	int error_runs;

	// per-run target behaviour drawn up front
	logic [7:0] stat_tab [NUM_SEQ];
	logic [7:0] kstat_tab [NUM_SEQ];
	bit hold_stat_tab [NUM_SEQ];
	bit hold_kstat_tab [NUM_SEQ];
	int restart_tab [NUM_SEQ];

	logic [7:0] stat_val;
	logic [7:0] kstat_val;
	bit hold_stat;
	bit hold_kstat;

	logic [7:0] tx_log [$];
	logic [7:0] exp_bytes [$];
	logic [7:0] rx_q [$];
	updi_pkg::error_code_e exp_code;
	updi_pkg::error_code_e prev_code;

	// target model state
	int brk_wait;
	int frame_pos;
	int pay_left;
	bit rsp_armed;
	int rsp_wait;
	logic [7:0] rsp_byte;

	bit run_active;
	bit break_due;

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS)) clock_gen (.clk(clk));

	updi_programmer uut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.error(error),
		.error_code(error_code),
		.uart_tx_data(uart_tx_data),
		.uart_tx_wr_en(uart_tx_wr_en),
		.uart_tx_full(uart_tx_full),
		.uart_rx_data(uart_rx_data),
		.uart_rx_rd_en(uart_rx_rd_en),
		.uart_rx_empty(uart_rx_empty),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done)
	);

	bind updi_programmer updi_programmer_sva sva_inst (
		.clk(clk),
		.rst(rst),
		.busy(busy),
		.done(done),
		.error(error),
		.error_code(error_code),
		.uart_tx_wr_en(uart_tx_wr_en),
		.uart_tx_full(uart_tx_full),
		.uart_rx_rd_en(uart_rx_rd_en),
		.uart_rx_empty(uart_rx_empty),
		.double_break_start(double_break_start)
	);

	task automatic report_mismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		errors++;
		$display("Fail at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
	endtask

	task automatic flag_problem(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// byte stream and result that the run should produce
	task automatic build_expected(input logic [7:0] stat, input logic [7:0] kstat,
		input bit hold_s, input bit hold_k);
		logic [63:0] key;
		int i;
		key = `UPDI_KEY_CHIPERASE;
		exp_bytes.delete();
		exp_bytes.push_back(`UPDI_SYNC);
		exp_bytes.push_back({`UPDI_OP_LDCS, 1'b0, `UPDI_CS_STATUSA});
		if (hold_s) begin
			exp_code = updi_pkg::ERR_RX_TIMEOUT;
			return;
		end
		if (stat == 8'h00) begin
			exp_code = updi_pkg::ERR_STATUS_ZERO;
			return;
		end
		exp_bytes.push_back(`UPDI_SYNC);
		exp_bytes.push_back({`UPDI_OP_KEY, 3'b000, `UPDI_KEY_SIZE_64});
		for (i = 0; i < 8; i++)
			exp_bytes.push_back(key[8 * i +: 8]);
		exp_bytes.push_back(`UPDI_SYNC);
		exp_bytes.push_back({`UPDI_OP_LDCS, 1'b0, `UPDI_CS_ASI_SYS_STATUS});
		if (hold_k) begin
			exp_code = updi_pkg::ERR_RX_TIMEOUT;
			return;
		end
		if (kstat[3]) begin
			exp_code = updi_pkg::ERR_KEY_STATUS;
			return;
		end
		exp_bytes.push_back(`UPDI_SYNC);
		exp_bytes.push_back({`UPDI_OP_STCS, 1'b0, `UPDI_CS_ASI_RESET_REQ});
		exp_bytes.push_back(`UPDI_RESET_SIGNATURE);
		exp_bytes.push_back(`UPDI_SYNC);
		exp_bytes.push_back({`UPDI_OP_STCS, 1'b0, `UPDI_CS_ASI_RESET_REQ});
		exp_bytes.push_back(8'h00);
		exp_code = updi_pkg::ERR_NONE;
	endtask

	task automatic compare_stream();
		int i;
		int n;
		if (tx_log.size() != exp_bytes.size())
			report_mismatch("tx byte count", exp_bytes.size(), tx_log.size());
		n = (tx_log.size() < exp_bytes.size()) ? tx_log.size() : exp_bytes.size();
		for (i = 0; i < n; i++) begin
			if (tx_log[i] !== exp_bytes[i])
				report_mismatch($sformatf("uart_tx_data byte %0d", i), exp_bytes[i], tx_log[i]);
		end
	endtask

	task automatic run_sequence(input int n);
		stat_val = stat_tab[n];
		kstat_val = kstat_tab[n];
		hold_stat = hold_stat_tab[n];
		hold_kstat = hold_kstat_tab[n];
		build_expected(stat_val, kstat_val, hold_stat, hold_kstat);
		// previous result must still be visible
		if (n > 0 && error_code !== prev_code)
			report_mismatch("error_code", prev_code, error_code);
		tx_log.delete();
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// a second start while busy must be ignored
		if (restart_tab[n] != 0) begin
			repeat (restart_tab[n]) @(posedge clk);
			if (busy !== 1'b1)
				flag_problem("DUT not busy when the extra start was issued");
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		do @(posedge clk); while (!(done || error));
		if (done !== (exp_code == updi_pkg::ERR_NONE))
			report_mismatch("done", exp_code == updi_pkg::ERR_NONE, done);
		if (error !== (exp_code != updi_pkg::ERR_NONE))
			report_mismatch("error", exp_code != updi_pkg::ERR_NONE, error);
		if (error_code !== exp_code)
			report_mismatch("error_code", exp_code, error_code);
		compare_stream();
		if (rx_q.size() != 0)
			flag_problem("response bytes left unread in the RX FIFO");
		if (exp_code == updi_pkg::ERR_NONE)
			done_runs++;
		else
			error_runs++;
		prev_code = exp_code;
		@(posedge clk);
	endtask

	// double break, TX FIFO, target and RX FIFO models
	always @(posedge clk) begin : fifo_models
		updi_pkg::opcode_u op_view;
		if (rst) begin
			brk_wait = 0;
			frame_pos = 0;
			pay_left = 0;
			rsp_armed = 1'b0;
			rx_q.delete();
			double_break_done <= 1'b0;
			uart_tx_full <= 1'b0;
			uart_rx_empty <= 1'b1;
		end else begin
			double_break_done <= 1'b0;
			if (double_break_start) begin
				brk_wait = 1 + {$random(seed)} % 20;
			end else if (brk_wait > 0) begin
				brk_wait = brk_wait - 1;
				if (brk_wait == 0)
					double_break_done <= 1'b1;
			end

			// log each written byte and follow the frame
			if (uart_tx_wr_en) begin
				tx_log.push_back(uart_tx_data);
				op_view = uart_tx_data;
				if (frame_pos == 0) begin
					frame_pos = 1;
				end else if (frame_pos == 1) begin
					frame_pos = 0;
					if (op_view.cs.op == `UPDI_OP_LDCS) begin
						if (op_view.cs.addr == `UPDI_CS_STATUSA && !hold_stat) begin
							rsp_byte = stat_val;
							rsp_wait = {$random(seed)} % 24;
							rsp_armed = 1'b1;
						end else if (op_view.cs.addr == `UPDI_CS_ASI_SYS_STATUS
							&& !hold_kstat) begin
							rsp_byte = kstat_val;
							rsp_wait = {$random(seed)} % 24;
							rsp_armed = 1'b1;
						end
					end else if (op_view.cs.op == `UPDI_OP_STCS) begin
						pay_left = 1;
						frame_pos = 2;
					end else if (op_view.key.op == `UPDI_OP_KEY) begin
						// size code 0 is 8 bytes and each step doubles
						pay_left = 8 << op_view.key.size;
						frame_pos = 2;
					end
				end else begin
					pay_left = pay_left - 1;
					if (pay_left == 0)
						frame_pos = 0;
				end
			end
			uart_tx_full <= ({$random(seed)} % 4) == 0;

			if (uart_rx_rd_en && rx_q.size() > 0)
				uart_rx_data <= rx_q.pop_front();
			else
				uart_rx_data <= $random(seed);

			if (rsp_armed) begin
				if (rsp_wait == 0) begin
					rx_q.push_back(rsp_byte);
					rsp_armed = 1'b0;
				end else begin
					rsp_wait = rsp_wait - 1;
				end
			end
			uart_rx_empty <= rx_q.size() == 0;
		end
	end

	// busy, break request and FIFO strobes every cycle
	always @(posedge clk) begin : control_checks
		if (rst) begin
			run_active = 1'b0;
			break_due = 1'b0;
		end else begin
			if (busy !== run_active)
				report_mismatch("busy", run_active, busy);
			if (double_break_start !== break_due)
				report_mismatch("double_break_start", break_due, double_break_start);
			if (uart_tx_wr_en && uart_tx_full)
				flag_problem("TX FIFO written while full");
			if (uart_rx_rd_en && uart_rx_empty)
				flag_problem("RX FIFO read while empty");
			if (done && error)
				flag_problem("done and error high in the same cycle");
			break_due = start && !run_active;
			if (start && !run_active)
				run_active = 1'b1;
			else if (done || error)
				run_active = 1'b0;
		end
	end

	initial begin : main_flow
		int i;
		rst = 1'b1;
		start = 1'b0;
		uart_tx_full = 1'b0;
		uart_rx_data = 8'h00;
		uart_rx_empty = 1'b1;
		double_break_done = 1'b0;
		seed = 54989;
		errors = 0;
		done_runs = 0;
		error_runs = 0;
		prev_code = updi_pkg::ERR_NONE;
		stat_val = 8'h00;
		kstat_val = 8'h00;
		hold_stat = 1'b0;
		hold_kstat = 1'b0;

		// zero status and bit 3 set both show up often
		for (i = 0; i < NUM_SEQ; i++) begin
			stat_tab[i] = $random(seed);
			if ({$random(seed)} % 4 == 0)
				stat_tab[i] = 8'h00;
			kstat_tab[i] = $random(seed) & 8'hF7;
			if ({$random(seed)} % 4 == 0)
				kstat_tab[i][3] = 1'b1;
			hold_stat_tab[i] = ({$random(seed)} % 10) == 0;
			hold_kstat_tab[i] = ({$random(seed)} % 10) == 0;
			restart_tab[i] = {$random(seed)} % 3;
		end

		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		if (busy !== 1'b0)
			report_mismatch("busy", 0, busy);
		if (done !== 1'b0 || error !== 1'b0)
			flag_problem("end pulse active right after reset");
		if (double_break_start !== 1'b0)
			report_mismatch("double_break_start", 0, double_break_start);
		if (uart_tx_wr_en !== 1'b0 || uart_rx_rd_en !== 1'b0)
			flag_problem("FIFO strobe active right after reset");
		if (error_code !== updi_pkg::ERR_NONE)
			report_mismatch("error_code", updi_pkg::ERR_NONE, error_code);

		for (i = 0; i < NUM_SEQ; i++)
			run_sequence(i);

		repeat (4) @(posedge clk);
		$display("runs %0d, done %0d, error %0d, errors %0d",
			NUM_SEQ, done_runs, error_runs, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: the programming runs did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* test/updi_programmer_sva.sv */
// UPDI programmer assertions
`timescale 1ns/1ps
`default_nettype none

module updi_programmer_sva (
	input wire logic clk,
	input wire logic rst,
	input wire logic busy,
	input wire logic done,
	input wire logic error,
	input wire logic [1:0] error_code,
	input wire logic uart_tx_wr_en,
	input wire logic uart_tx_full,
	input wire logic uart_rx_rd_en,
	input wire logic uart_rx_empty,
	input wire logic double_break_start
);

	// no push into a full TX FIFO
	tx_full_respected: assert property (@(posedge clk) disable iff (rst)
		uart_tx_wr_en |-> !uart_tx_full)
		else $error("uart_tx_wr_en high while uart_tx_full is high");

	// no pop from an empty RX FIFO
	rx_empty_respected: assert property (@(posedge clk) disable iff (rst)
		uart_rx_rd_en |-> !uart_rx_empty)
		else $error("uart_rx_rd_en high while uart_rx_empty is high");

	// a run ends one way only
	single_end_pulse: assert property (@(posedge clk) disable iff (rst)
		!(done && error))
		else $error("done and error high in the same cycle");

	// everything quiet once reset has been applied
	reset_state: assert property (@(posedge clk)
		rst |=> !busy && !done && !error && !double_break_start
			&& !uart_tx_wr_en && !uart_rx_rd_en
			&& error_code == updi_pkg::ERR_NONE)
		else $error("control outputs not idle after reset");

endmodule

`default_nettype wire
